// File: verilog.f
+incdir+rtl
rtl/csr_types_pkg.sv
rtl/csr_bus_pkg.sv
rtl/csr_addr_decode.sv
rtl/csr_trap_ctrl.sv
rtl/csr_regfile.sv
rtl/csr_read_mux.sv
rtl/csr_top.sv
tb/csr_chk.sv
tb/csr_tb.sv

// File: Bender.yml
package:
  name: csr_file

export_include_dirs:
  - rtl

sources:
  # RTL, packages first
  - include_dirs:
      - rtl
    files:
      - rtl/csr_types_pkg.sv
      - rtl/csr_bus_pkg.sv
      - rtl/csr_addr_decode.sv
      - rtl/csr_trap_ctrl.sv
      - rtl/csr_regfile.sv
      - rtl/csr_read_mux.sv
      - rtl/csr_top.sv

  # Testbench
  - target: test
    include_dirs:
      - rtl
    files:
      - tb/csr_chk.sv
      - tb/csr_tb.sv

// File: tb/csr_tb.sv
// CSR file testbench
// Reference model of the CSRs, directed and random stimulus, self-checking compare
`include "csr_consts.svh"

module csr_tb
    import csr_types_pkg::*;
    import csr_bus_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    // Cycles used by each test, in test order
    localparam int TEST_CYCLES = 111 + 37 + 24 * 13 + 2 + 16 * 12 + 11 + 4 * 23;
    localparam int WATCHDOG_CYCLES = TEST_CYCLES + 200;
    localparam word_t MSTATUS_MASK = 32'h0040_19aa;
    localparam word_t SSTATUS_MASK = 32'h0000_0122;
    localparam csr_addr_t RW_ADDRS [13] = '{
        `CSR_ADDR_MSTATUS, `CSR_ADDR_MEDELEG, `CSR_ADDR_MTVEC, `CSR_ADDR_MSCRATCH,
        `CSR_ADDR_MEPC, `CSR_ADDR_MCAUSE, `CSR_ADDR_MTVAL, `CSR_ADDR_SSTATUS,
        `CSR_ADDR_STVEC, `CSR_ADDR_SSCRATCH, `CSR_ADDR_SEPC, `CSR_ADDR_SCAUSE,
        `CSR_ADDR_STVAL
    };
    localparam csr_addr_t RO_ADDRS [7] = '{
        `CSR_ADDR_MISA, `CSR_ADDR_MVENDORID, `CSR_ADDR_MARCHID, `CSR_ADDR_MIMPID,
        `CSR_ADDR_MHARTID, `CSR_ADDR_CYCLE, `CSR_ADDR_CYCLEH
    };

    logic      clk;
    logic      rst;
    csr_addr_t rd_addr;
    word_t     rd_data;
    logic      rd_illegal;
    csr_wr_t   wr;
    trap_req_t trap;
    xret_req_t xret;
    word_t     next_pc;
    priv_e     priv;
    status_t   mstatus;
    logic      tsr;

    // Reference model, indexed by CSR address
    word_t       m_reg [0:4095];
    logic [1:0]  m_priv;
    logic [63:0] ref_cycle;
    word_t       last_rd;
    logic        chk_en;
    int          n_checks;
    int          n_errors;
    int          n_tests;
    int          n_failed;
    int          err_mark;

    csr_top i_dut (
        .clk        (clk),
        .rst        (rst),
        .rd_addr    (rd_addr),
        .rd_data    (rd_data),
        .rd_illegal (rd_illegal),
        .wr         (wr),
        .trap       (trap),
        .xret       (xret),
        .next_pc    (next_pc),
        .priv       (priv),
        .mstatus    (mstatus),
        .tsr        (tsr)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        if (rst) begin
            ref_cycle <= '0;
        end else begin
            ref_cycle <= ref_cycle + 1;
        end
    end

    // -------------------------------------------------------------------------
    // Reference model
    function automatic logic is_impl(csr_addr_t a);
        case (a)
            `CSR_ADDR_MSTATUS, `CSR_ADDR_MISA, `CSR_ADDR_MEDELEG, `CSR_ADDR_MTVEC,
            `CSR_ADDR_MSCRATCH, `CSR_ADDR_MEPC, `CSR_ADDR_MCAUSE, `CSR_ADDR_MTVAL,
            `CSR_ADDR_SSTATUS, `CSR_ADDR_STVEC, `CSR_ADDR_SSCRATCH, `CSR_ADDR_SEPC,
            `CSR_ADDR_SCAUSE, `CSR_ADDR_STVAL, `CSR_ADDR_CYCLE, `CSR_ADDR_CYCLEH,
            `CSR_ADDR_MVENDORID, `CSR_ADDR_MARCHID, `CSR_ADDR_MIMPID,
            `CSR_ADDR_MHARTID: return 1'b1;
            default:           return 1'b0;
        endcase
    endfunction

    // Expected {rd_illegal, rd_data}
    function automatic logic [32:0] ref_read(csr_addr_t a);
        word_t d;
        if (!is_impl(a) || a[9:8] > m_priv) begin
            return {1'b1, 32'h0};
        end
        case (a)
            `CSR_ADDR_SSTATUS:   d = m_reg[`CSR_ADDR_MSTATUS] & SSTATUS_MASK;
            `CSR_ADDR_MISA:      d = `CSR_MISA_VALUE;
            `CSR_ADDR_CYCLE:     d = ref_cycle[31:0];
            `CSR_ADDR_CYCLEH:    d = ref_cycle[63:32];
            `CSR_ADDR_MVENDORID: d = `CSR_VENDOR_ID;
            `CSR_ADDR_MARCHID:   d = `CSR_ARCH_ID;
            `CSR_ADDR_MIMPID:    d = `CSR_IMPL_ID;
            `CSR_ADDR_MHARTID:   d = `CSR_HART_ID;
            default:             d = m_reg[a];
        endcase
        return {1'b0, d};
    endfunction

    function automatic word_t ref_next_pc();
        if (trap.valid) begin
            if (m_reg[`CSR_ADDR_MEDELEG][trap.cause]) begin
                return m_reg[`CSR_ADDR_STVEC] & ~32'h3;
            end
            return m_reg[`CSR_ADDR_MTVEC] & ~32'h3;
        end
        if (xret.valid) begin
            return (xret.priv == PRIV_M) ? m_reg[`CSR_ADDR_MEPC] : m_reg[`CSR_ADDR_SEPC];
        end
        return '0;
    endfunction

    task automatic model_write(csr_addr_t a, word_t d);
        word_t old;
        old = m_reg[`CSR_ADDR_MSTATUS];
        if (!is_impl(a) || &a[11:10] || a[9:8] > m_priv) begin
            return;
        end
        case (a)
            `CSR_ADDR_MSTATUS: begin
                m_reg[a] = (old & ~MSTATUS_MASK) | (d & MSTATUS_MASK);
                // Reserved mpp encoding leaves mpp alone
                if (d[12:11] == 2'b10) begin
                    m_reg[a][12:11] = old[12:11];
                end
            end
            `CSR_ADDR_SSTATUS: begin
                m_reg[`CSR_ADDR_MSTATUS] = (old & ~SSTATUS_MASK) | (d & SSTATUS_MASK);
            end
            `CSR_ADDR_MCAUSE, `CSR_ADDR_SCAUSE: m_reg[a] = {28'h0, d[3:0]};
            default: m_reg[a] = d;
        endcase
    endtask

    // Applied at the clock edge, with the inputs of the cycle that ends there
    task automatic model_update();
        word_t      st;
        logic [1:0] old;
        st  = m_reg[`CSR_ADDR_MSTATUS];
        old = m_priv;
        if (!trap.valid && !xret.valid) begin
            if (wr.valid) begin
                model_write(wr.addr, wr.data);
            end
            return;
        end
        if (trap.valid && m_reg[`CSR_ADDR_MEDELEG][trap.cause]) begin
            m_reg[`CSR_ADDR_SEPC]   = trap.pc;
            m_reg[`CSR_ADDR_SCAUSE] = {28'h0, trap.cause};
            m_reg[`CSR_ADDR_STVAL]  = trap.tval;
            st[8]  = old[0];
            m_priv = PRIV_S;
        end else if (trap.valid) begin
            m_reg[`CSR_ADDR_MEPC]   = trap.pc;
            m_reg[`CSR_ADDR_MCAUSE] = {28'h0, trap.cause};
            m_reg[`CSR_ADDR_MTVAL]  = trap.tval;
            st[12:11] = old;
            m_priv    = PRIV_M;
        end else if (xret.priv == PRIV_M) begin
            m_priv    = st[12:11];
            st[3]     = st[7];
            st[12:11] = 2'b00;
        end else begin
            m_priv = st[8] ? PRIV_S : PRIV_U;
            st[1]  = st[5];
            st[8]  = 1'b0;
        end
        m_reg[`CSR_ADDR_MSTATUS] = st;
    endtask

    // -------------------------------------------------------------------------
    // Checking
    task automatic check(logic [63:0] got, logic [63:0] exp, string what);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("FAILED at %0d ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    // Outputs settle 1 ns after the inputs change on the falling edge
    initial begin : compare
        logic [32:0] exp_rd;
        forever begin
            @(negedge clk);
            #1;
            if (chk_en) begin
                exp_rd = ref_read(rd_addr);
                check(rd_illegal, exp_rd[32], $sformatf("rd_illegal @%h", rd_addr));
                check(rd_data, exp_rd[31:0], $sformatf("rd_data @%h", rd_addr));
                check(next_pc, ref_next_pc(), "next_pc");
                check(priv, m_priv, "priv");
                check(mstatus, m_reg[`CSR_ADDR_MSTATUS], "mstatus");
                check(tsr, m_reg[`CSR_ADDR_MSTATUS][22], "tsr");
            end
        end
    end

    initial begin : watchdog
        #(WATCHDOG_CYCLES * 4);
        $display("Timeout: tests did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("SOME TESTS FAILED");
        $finish;
    end

    // -------------------------------------------------------------------------
    // Stimulus helpers, one clock cycle each
    task automatic step(csr_addr_t ra, csr_wr_t w, trap_req_t t, xret_req_t x);
        @(negedge clk);
        rd_addr = ra;
        wr      = w;
        trap    = t;
        xret    = x;
        #1.5;
        last_rd = rd_data;
        @(posedge clk);
        model_update();
    endtask

    task automatic read_csr(csr_addr_t a);
        step(a, '0, '0, '0);
    endtask

    task automatic write_csr(csr_addr_t a, word_t d);
        step(a, {1'b1, a, d}, '0, '0);
    endtask

    task automatic raise_trap(exc_code_t c, word_t tval, word_t pc);
        step(`CSR_ADDR_MEPC, '0, {1'b1, c, tval, pc}, '0);
    endtask

    task automatic return_from(priv_e p);
        step(p == PRIV_M ? `CSR_ADDR_MEPC : `CSR_ADDR_SEPC, '0, '0, {1'b1, p});
    endtask

    // Cause 15 is never delegated by these tests
    task automatic enter_machine();
        raise_trap(4'd15, $urandom, $urandom);
    endtask

    task automatic finish_test(string name);
        n_tests++;
        if (n_errors == err_mark) begin
            $display("test %0d %s: passed", n_tests, name);
        end else begin
            n_failed++;
            $display("test %0d %s: failed with %0d errors", n_tests, name, n_errors - err_mark);
        end
        err_mark = n_errors;
    endtask

    // -------------------------------------------------------------------------
    // Tests
    task automatic test_read_write();
        for (int r = 0; r < 4; r++) begin
            foreach (RW_ADDRS[i]) begin
                write_csr(RW_ADDRS[i], $urandom);
                read_csr(RW_ADDRS[i]);
            end
        end
        foreach (RO_ADDRS[i]) begin
            read_csr(RO_ADDRS[i]);
        end
        finish_test("read/write at M");
    endtask

    task automatic test_access_rules();
        write_csr(`CSR_ADDR_MEDELEG, 32'h0);
        read_csr(12'h180);
        read_csr(12'h7b0);
        repeat (12) read_csr(csr_addr_t'($urandom));
        write_csr(`CSR_ADDR_CYCLE, $urandom);
        write_csr(`CSR_ADDR_MHARTID, $urandom);
        write_csr(12'h180, $urandom);
        // Down to S through mret, then to U through sret
        write_csr(`CSR_ADDR_MSTATUS, 32'h0000_0800);
        write_csr(`CSR_ADDR_MEPC, 32'h0000_1000);
        return_from(PRIV_M);
        read_csr(`CSR_ADDR_MSTATUS);
        read_csr(`CSR_ADDR_MTVEC);
        read_csr(`CSR_ADDR_SSTATUS);
        read_csr(`CSR_ADDR_CYCLEH);
        write_csr(`CSR_ADDR_MSCRATCH, $urandom);
        write_csr(`CSR_ADDR_SSCRATCH, $urandom);
        return_from(PRIV_S);
        read_csr(`CSR_ADDR_SSTATUS);
        read_csr(`CSR_ADDR_SEPC);
        read_csr(`CSR_ADDR_CYCLE);
        write_csr(`CSR_ADDR_SSCRATCH, $urandom);
        write_csr(`CSR_ADDR_MEDELEG, $urandom);
        enter_machine();
        read_csr(`CSR_ADDR_MSCRATCH);
        read_csr(`CSR_ADDR_SSCRATCH);
        read_csr(`CSR_ADDR_MEDELEG);
        finish_test("access rules");
    endtask

    task automatic test_traps();
        repeat (24) begin
            enter_machine();
            write_csr(`CSR_ADDR_MEDELEG, $urandom & 32'h0000_7fff);
            write_csr(`CSR_ADDR_MSTATUS, $urandom);
            // Random starting level for the trap
            return_from(PRIV_M);
            raise_trap(exc_code_t'($urandom), $urandom, $urandom);
            read_csr(`CSR_ADDR_MEPC);
            read_csr(`CSR_ADDR_MCAUSE);
            read_csr(`CSR_ADDR_MTVAL);
            read_csr(`CSR_ADDR_MSTATUS);
            read_csr(`CSR_ADDR_SEPC);
            read_csr(`CSR_ADDR_SCAUSE);
            read_csr(`CSR_ADDR_STVAL);
            read_csr(`CSR_ADDR_SSTATUS);
        end
        finish_test("trap delegation");
    endtask

    task automatic test_returns();
        enter_machine();
        write_csr(`CSR_ADDR_MEDELEG, 32'h0);
        repeat (16) begin
            write_csr(`CSR_ADDR_MSTATUS, $urandom);
            write_csr(`CSR_ADDR_MEPC, $urandom);
            return_from(PRIV_M);
            read_csr(`CSR_ADDR_SSTATUS);
            enter_machine();
            read_csr(`CSR_ADDR_MSTATUS);
            write_csr(`CSR_ADDR_SSTATUS, $urandom);
            write_csr(`CSR_ADDR_SEPC, $urandom);
            return_from(PRIV_S);
            read_csr(`CSR_ADDR_SSTATUS);
            enter_machine();
            read_csr(`CSR_ADDR_MSTATUS);
        end
        finish_test("mret and sret");
    endtask

    task automatic test_write_collision();
        enter_machine();
        step(`CSR_ADDR_MSCRATCH, {1'b1, `CSR_ADDR_MSCRATCH, $urandom},
             {1'b1, 4'd2, $urandom, $urandom}, '0);
        read_csr(`CSR_ADDR_MSCRATCH);
        step(`CSR_ADDR_MTVEC, {1'b1, `CSR_ADDR_MTVEC, $urandom},
             {1'b1, 4'd5, $urandom, $urandom}, '0);
        read_csr(`CSR_ADDR_MTVEC);
        step(`CSR_ADDR_MSCRATCH, {1'b1, `CSR_ADDR_MSCRATCH, $urandom}, '0, {1'b1, PRIV_M});
        enter_machine();
        read_csr(`CSR_ADDR_MSCRATCH);
        step(`CSR_ADDR_SSTATUS, {1'b1, `CSR_ADDR_SSTATUS, 32'h0000_0122}, '0, {1'b1, PRIV_S});
        enter_machine();
        read_csr(`CSR_ADDR_SSTATUS);
        finish_test("write against trap and return");
    endtask

    task automatic test_cycle_count();
        word_t c0;
        int    n;
        repeat (4) begin
            n = 2 + $urandom % 20;
            read_csr(`CSR_ADDR_CYCLE);
            c0 = last_rd;
            repeat (n) read_csr(`CSR_ADDR_CYCLEH);
            read_csr(`CSR_ADDR_CYCLE);
            check(last_rd - c0, n + 1, "cycle delta");
        end
        finish_test("cycle counter");
    endtask

    initial begin : stimulus
        void'($urandom(22425));
        rst     = 1'b1;
        rd_addr = '0;
        wr      = '0;
        trap    = '0;
        xret    = '0;
        chk_en  = 1'b0;
        m_priv  = PRIV_M;
        foreach (m_reg[i]) begin
            m_reg[i] = '0;
        end
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst    = 1'b0;
        chk_en = 1'b1;

        test_read_write();
        test_access_rules();
        test_traps();
        test_returns();
        test_write_collision();
        test_cycle_count();

        chk_en = 1'b0;
        $display("%0d tests, %0d failed, %0d checks, %0d errors, %0d assertion failures",
                 n_tests, n_failed, n_checks, n_errors, i_dut.i_chk.n_fail);
        if (n_errors == 0 && i_dut.i_chk.n_fail == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: tb/csr_chk.sv
// CSR file assertion checker
// Concurrent checks on the redirect, privilege and status outputs
module csr_chk
    import csr_types_pkg::*;
    import csr_bus_pkg::*;
(
    input logic      clk,
    input logic      rst,
    input trap_req_t trap,
    input xret_req_t xret,
    input word_t     next_pc,
    input priv_e     priv,
    input status_t   mstatus,
    input logic      tsr
);
    timeunit 1ns;
    timeprecision 100ps;

    // Number of failed assertions
    int n_fail = 0;

    // No redirect without a trap or a return
    a_pc_idle: assert property (@(posedge clk) disable iff (rst)
        !(trap.valid || xret.valid) |-> next_pc == '0)
        else begin
            n_fail++;
            $error("next_pc is nonzero with no trap or return pending");
        end

    // Encoding 2 is reserved
    a_priv_legal: assert property (@(posedge clk) disable iff (rst) priv != 2'd2)
        else begin
            n_fail++;
            $error("priv holds the reserved encoding");
        end

    a_priv_reset: assert property (@(posedge clk) rst |=> priv == PRIV_M)
        else begin
            n_fail++;
            $error("priv is not M after reset");
        end

    a_tsr_mirror: assert property (@(posedge clk) disable iff (rst) tsr == mstatus.tsr)
        else begin
            n_fail++;
            $error("tsr output differs from mstatus.tsr");
        end

endmodule

bind csr_top csr_chk i_chk (
    .clk     (clk),
    .rst     (rst),
    .trap    (trap),
    .xret    (xret),
    .next_pc (next_pc),
    .priv    (priv),
    .mstatus (mstatus),
    .tsr     (tsr)
);

// File: rtl/csr_top.sv
// CSR file top level
// Wires address decode, trap control, register file and read mux together
`include "csr_consts.svh"

module csr_top
    import csr_types_pkg::*;
    import csr_bus_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  csr_addr_t rd_addr,
    output word_t     rd_data,
    output logic      rd_illegal,
    input  csr_wr_t   wr,
    input  trap_req_t trap,
    input  xret_req_t xret,
    output word_t     next_pc,
    output priv_e     priv,
    output status_t   mstatus,
    output logic      tsr
);

    csr_sel_e                rd_sel;
    csr_sel_e                wr_sel;
    trap_upd_t               upd;
    word_t                   medeleg;
    word_t                   mtvec;
    word_t                   stvec;
    word_t                   mepc;
    word_t                   sepc;
    word_t                   mscratch;
    word_t                   sscratch;
    word_t                   mtval;
    word_t                   stval;
    exc_code_t               mcause;
    exc_code_t               scause;
    logic [2*`CSR_XLEN-1:0]  cycle;

    assign tsr = mstatus.tsr;

    // Decode stage
    csr_addr_decode i_decode (
        .rd_addr    (rd_addr),
        .wr_addr    (wr.addr),
        .wr_valid   (wr.valid),
        .priv       (priv),
        .rd_sel     (rd_sel),
        .wr_sel     (wr_sel),
        .rd_illegal (rd_illegal)
    );

    // Execute stage
    csr_trap_ctrl i_trap_ctrl (
        .trap    (trap),
        .xret    (xret),
        .priv    (priv),
        .status  (mstatus),
        .medeleg (medeleg),
        .mtvec   (mtvec),
        .stvec   (stvec),
        .mepc    (mepc),
        .sepc    (sepc),
        .upd     (upd),
        .next_pc (next_pc)
    );

    csr_regfile i_regfile (
        .clk      (clk),
        .rst      (rst),
        .wr_sel   (wr_sel),
        .wr_data  (wr.data),
        .trap     (trap),
        .upd      (upd),
        .priv     (priv),
        .status   (mstatus),
        .medeleg  (medeleg),
        .mtvec    (mtvec),
        .stvec    (stvec),
        .mepc     (mepc),
        .sepc     (sepc),
        .mscratch (mscratch),
        .sscratch (sscratch),
        .mtval    (mtval),
        .stval    (stval),
        .mcause   (mcause),
        .scause   (scause),
        .cycle    (cycle)
    );

    // Result stage
    csr_read_mux i_read_mux (
        .rd_sel   (rd_sel),
        .status   (mstatus),
        .medeleg  (medeleg),
        .mtvec    (mtvec),
        .stvec    (stvec),
        .mepc     (mepc),
        .sepc     (sepc),
        .mscratch (mscratch),
        .sscratch (sscratch),
        .mtval    (mtval),
        .stval    (stval),
        .mcause   (mcause),
        .scause   (scause),
        .cycle    (cycle),
        .rd_data  (rd_data)
    );

endmodule

// File: rtl/csr_read_mux.sv
// CSR read mux
// Selects and formats the read data, including masked and constant views
`include "csr_consts.svh"

module csr_read_mux
    import csr_types_pkg::*;
(
    input  csr_sel_e               rd_sel,
    input  status_t                status,
    input  word_t                  medeleg,
    input  word_t                  mtvec,
    input  word_t                  stvec,
    input  word_t                  mepc,
    input  word_t                  sepc,
    input  word_t                  mscratch,
    input  word_t                  sscratch,
    input  word_t                  mtval,
    input  word_t                  stval,
    input  exc_code_t              mcause,
    input  exc_code_t              scause,
    input  logic [2*`CSR_XLEN-1:0] cycle,
    output word_t                  rd_data
);

    status_t sstatus_view;

    always_comb begin
        // Supervisor view shows spp, spie and sie only
        sstatus_view      = '0;
        sstatus_view.spp  = status.spp;
        sstatus_view.spie = status.spie;
        sstatus_view.sie  = status.sie;

        case (rd_sel)
            SEL_MSTATUS:   rd_data = status;
            SEL_MISA:      rd_data = `CSR_MISA_VALUE;
            SEL_MEDELEG:   rd_data = medeleg;
            SEL_MTVEC:     rd_data = mtvec;
            SEL_MSCRATCH:  rd_data = mscratch;
            SEL_MEPC:      rd_data = mepc;
            SEL_MCAUSE:    rd_data = word_t'(mcause);
            SEL_MTVAL:     rd_data = mtval;
            SEL_SSTATUS:   rd_data = sstatus_view;
            SEL_STVEC:     rd_data = stvec;
            SEL_SSCRATCH:  rd_data = sscratch;
            SEL_SEPC:      rd_data = sepc;
            SEL_SCAUSE:    rd_data = word_t'(scause);
            SEL_STVAL:     rd_data = stval;
            SEL_CYCLE:     rd_data = cycle[`CSR_XLEN-1:0];
            SEL_CYCLEH:    rd_data = cycle[2*`CSR_XLEN-1:`CSR_XLEN];
            SEL_MVENDORID: rd_data = `CSR_VENDOR_ID;
            SEL_MARCHID:   rd_data = `CSR_ARCH_ID;
            SEL_MIMPID:    rd_data = `CSR_IMPL_ID;
            SEL_MHARTID:   rd_data = `CSR_HART_ID;
            default:       rd_data = '0;
        endcase
    end

endmodule

// File: rtl/csr_regfile.sv
// CSR register file
// Holds all CSR state and the cycle counter, applies trap updates and writes
`include "csr_consts.svh"

module csr_regfile
    import csr_types_pkg::*;
    import csr_bus_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst,
    input  csr_sel_e                wr_sel,
    input  word_t                   wr_data,
    input  trap_req_t               trap,
    input  trap_upd_t               upd,
    output priv_e                   priv,
    output status_t                 status,
    output word_t                   medeleg,
    output word_t                   mtvec,
    output word_t                   stvec,
    output word_t                   mepc,
    output word_t                   sepc,
    output word_t                   mscratch,
    output word_t                   sscratch,
    output word_t                   mtval,
    output word_t                   stval,
    output exc_code_t               mcause,
    output exc_code_t               scause,
    output logic [2*`CSR_XLEN-1:0]  cycle
);

    status_t wr_status;
    status_t status_wr_next;

    // ---------------------------------------------------------------------
    // Status write masking
    always_comb begin
        wr_status      = status_t'(wr_data);
        status_wr_next = status;

        if (wr_sel == SEL_MSTATUS) begin
            status_wr_next.tsr  = wr_status.tsr;
            status_wr_next.mpie = wr_status.mpie;
            status_wr_next.mie  = wr_status.mie;
            // Reserved mpp encoding keeps the old value
            if (wr_status.mpp != 2'b10) begin
                status_wr_next.mpp = wr_status.mpp;
            end
        end

        // Fields shared by the mstatus and sstatus views
        if (wr_sel == SEL_MSTATUS || wr_sel == SEL_SSTATUS) begin
            status_wr_next.spp  = wr_status.spp;
            status_wr_next.spie = wr_status.spie;
            status_wr_next.sie  = wr_status.sie;
        end
    end

    // ---------------------------------------------------------------------
    // State registers
    always_ff @(posedge clk) begin
        if (rst) begin
            priv     <= PRIV_M;
            status   <= '0;
            medeleg  <= '0;
            mtvec    <= '0;
            stvec    <= '0;
            mepc     <= '0;
            sepc     <= '0;
            mscratch <= '0;
            sscratch <= '0;
            mtval    <= '0;
            stval    <= '0;
            mcause   <= '0;
            scause   <= '0;
            cycle    <= '0;
        end else begin
            cycle <= cycle + 1'b1;

            if (upd.valid) begin
                // Trap or return wins, any write this cycle is lost
                priv   <= upd.next_priv;
                status <= upd.next_status;
                if (trap.valid && upd.to_s) begin
                    sepc   <= trap.pc;
                    scause <= trap.cause;
                    stval  <= trap.tval;
                end else if (trap.valid) begin
                    mepc   <= trap.pc;
                    mcause <= trap.cause;
                    mtval  <= trap.tval;
                end
            end else begin
                status <= status_wr_next;
                case (wr_sel)
                    SEL_MEDELEG:  medeleg  <= wr_data;
                    SEL_MTVEC:    mtvec    <= wr_data;
                    SEL_STVEC:    stvec    <= wr_data;
                    SEL_MEPC:     mepc     <= wr_data;
                    SEL_SEPC:     sepc     <= wr_data;
                    SEL_MSCRATCH: mscratch <= wr_data;
                    SEL_SSCRATCH: sscratch <= wr_data;
                    SEL_MTVAL:    mtval    <= wr_data;
                    SEL_STVAL:    stval    <= wr_data;
                    SEL_MCAUSE:   mcause   <= wr_data[`CSR_CAUSE_W-1:0];
                    SEL_SCAUSE:   scause   <= wr_data[`CSR_CAUSE_W-1:0];
                    default:      ;
                endcase
            end
        end
    end

endmodule

// File: rtl/csr_trap_ctrl.sv
// CSR trap control
// Next privilege, edited status and redirect target for traps and returns
`include "csr_consts.svh"

module csr_trap_ctrl
    import csr_types_pkg::*;
    import csr_bus_pkg::*;
(
    input  trap_req_t trap,
    input  xret_req_t xret,
    input  priv_e     priv,
    input  status_t   status,
    input  word_t     medeleg,
    input  word_t     mtvec,
    input  word_t     stvec,
    input  word_t     mepc,
    input  word_t     sepc,
    output trap_upd_t upd,
    output word_t     next_pc
);

    logic    to_s;
    priv_e   next_priv;
    status_t next_status;

    always_comb begin
        to_s        = 1'b0;
        next_priv   = priv;
        next_status = status;
        next_pc     = '0;

        if (trap.valid) begin
            // Delegated causes go to S, everything else to M
            to_s = medeleg[trap.cause];
            if (to_s) begin
                next_priv       = PRIV_S;
                next_status.spp = priv[0];
                next_pc         = {stvec[`CSR_XLEN-1:2], 2'b00};
            end else begin
                next_priv       = PRIV_M;
                next_status.mpp = priv;
                next_pc         = {mtvec[`CSR_XLEN-1:2], 2'b00};
            end
        end else if (xret.valid) begin
            if (xret.priv == PRIV_M) begin
                // mret
                next_priv       = priv_e'(status.mpp);
                next_status.mie = status.mpie;
                next_status.mpp = PRIV_U;
                next_pc         = mepc;
            end else begin
                // sret; no uret, so any other level returns through sepc
                next_priv       = status.spp ? PRIV_S : PRIV_U;
                next_status.sie = status.spie;
                next_status.spp = 1'b0;
                next_pc         = sepc;
            end
        end
    end

    // ---------------------------------------------------------------------
    // Update record for the register file
    always_comb begin
        upd.valid       = trap.valid | xret.valid;
        upd.to_s        = to_s;
        upd.next_priv   = next_priv;
        upd.next_status = next_status;
    end

endmodule

// File: rtl/csr_addr_decode.sv
// CSR address decode
// Turns read and write addresses into register selects with access checks
`include "csr_consts.svh"

module csr_addr_decode
    import csr_types_pkg::*;
(
    input  csr_addr_t rd_addr,
    input  csr_addr_t wr_addr,
    input  logic      wr_valid,
    input  priv_e     priv,
    output csr_sel_e  rd_sel,
    output csr_sel_e  wr_sel,
    output logic      rd_illegal
);

    function automatic csr_sel_e decode_sel(csr_addr_t addr);
        case (addr)
            `CSR_ADDR_MSTATUS:   return SEL_MSTATUS;
            `CSR_ADDR_MISA:      return SEL_MISA;
            `CSR_ADDR_MEDELEG:   return SEL_MEDELEG;
            `CSR_ADDR_MTVEC:     return SEL_MTVEC;
            `CSR_ADDR_MSCRATCH:  return SEL_MSCRATCH;
            `CSR_ADDR_MEPC:      return SEL_MEPC;
            `CSR_ADDR_MCAUSE:    return SEL_MCAUSE;
            `CSR_ADDR_MTVAL:     return SEL_MTVAL;
            `CSR_ADDR_SSTATUS:   return SEL_SSTATUS;
            `CSR_ADDR_STVEC:     return SEL_STVEC;
            `CSR_ADDR_SSCRATCH:  return SEL_SSCRATCH;
            `CSR_ADDR_SEPC:      return SEL_SEPC;
            `CSR_ADDR_SCAUSE:    return SEL_SCAUSE;
            `CSR_ADDR_STVAL:     return SEL_STVAL;
            `CSR_ADDR_CYCLE:     return SEL_CYCLE;
            `CSR_ADDR_CYCLEH:    return SEL_CYCLEH;
            `CSR_ADDR_MVENDORID: return SEL_MVENDORID;
            `CSR_ADDR_MARCHID:   return SEL_MARCHID;
            `CSR_ADDR_MIMPID:    return SEL_MIMPID;
            `CSR_ADDR_MHARTID:   return SEL_MHARTID;
            default:             return SEL_NONE;
        endcase
    endfunction

    csr_sel_e rd_hit;
    csr_sel_e wr_hit;
    logic     rd_priv_ok;
    logic     wr_priv_ok;
    logic     wr_read_only;

    always_comb begin
        rd_hit = decode_sel(rd_addr);
        wr_hit = decode_sel(wr_addr);

        // Bits 9:8 give the lowest privilege allowed to touch the CSR
        rd_priv_ok   = rd_addr[9:8] <= priv;
        wr_priv_ok   = wr_addr[9:8] <= priv;
        wr_read_only = &wr_addr[11:10];

        rd_illegal = (rd_hit == SEL_NONE) || !rd_priv_ok;
        rd_sel     = rd_illegal ? SEL_NONE : rd_hit;

        if (wr_valid && wr_hit != SEL_NONE && !wr_read_only && wr_priv_ok) begin
            wr_sel = wr_hit;
        end else begin
            wr_sel = SEL_NONE;
        end
    end

endmodule

// File: rtl/csr_bus_pkg.sv
// CSR request and update structs
// Carried between the top level, trap control and the register file
`include "csr_consts.svh"

package csr_bus_pkg;
    import csr_types_pkg::*;

    // CSR instruction write
    typedef struct packed {
        logic      valid;
        csr_addr_t addr;
        word_t     data;
    } csr_wr_t;

    // Exception raised by the pipeline
    typedef struct packed {
        logic      valid;
        exc_code_t cause;
        word_t     tval;
        word_t     pc;
    } trap_req_t;

    // mret or sret, priv is the level being returned from
    typedef struct packed {
        logic  valid;
        priv_e priv;
    } xret_req_t;

    // Privilege and status update for a trap or a return
    typedef struct packed {
        logic    valid;
        logic    to_s;
        priv_e   next_priv;
        status_t next_status;
    } trap_upd_t;

endpackage

// File: rtl/csr_types_pkg.sv
// CSR architectural types
// Data words, privilege levels, mstatus layout and register selects
`include "csr_consts.svh"

package csr_types_pkg;

    typedef logic [`CSR_XLEN-1:0]    word_t;
    typedef logic [11:0]             csr_addr_t;
    typedef logic [`CSR_CAUSE_W-1:0] exc_code_t;

    // Encoding 2 is reserved
    typedef enum logic [1:0] {
        PRIV_U = 2'd0,
        PRIV_S = 2'd1,
        PRIV_M = 2'd3
    } priv_e;

    // mstatus, fields at their architectural positions
    typedef struct packed {
        logic [8:0] rsvd_31_23;
        logic       tsr;
        logic [8:0] rsvd_21_13;
        logic [1:0] mpp;
        logic [1:0] rsvd_10_9;
        logic       spp;
        logic       mpie;
        logic       rsvd_6;
        logic       spie;
        logic       rsvd_4;
        logic       mie;
        logic       rsvd_2;
        logic       sie;
        logic       rsvd_0;
    } status_t;

    typedef enum logic [4:0] {
        SEL_NONE,
        SEL_MSTATUS, SEL_MISA, SEL_MEDELEG, SEL_MTVEC, SEL_MSCRATCH,
        SEL_MEPC, SEL_MCAUSE, SEL_MTVAL,
        SEL_SSTATUS, SEL_STVEC, SEL_SSCRATCH, SEL_SEPC, SEL_SCAUSE, SEL_STVAL,
        SEL_CYCLE, SEL_CYCLEH,
        SEL_MVENDORID, SEL_MARCHID, SEL_MIMPID, SEL_MHARTID
    } csr_sel_e;

endpackage

// File: rtl/csr_consts.svh
// CSR constants for the RV32 machine/supervisor/user hart
// Architectural addresses, identity values and field widths
`ifndef CSR_CONSTS_SVH
`define CSR_CONSTS_SVH

`define CSR_XLEN    32
`define CSR_CAUSE_W 4

// -------------------------------------------------------------------------
// Supervisor trap setup and handling
`define CSR_ADDR_SSTATUS   12'h100
`define CSR_ADDR_STVEC     12'h105
`define CSR_ADDR_SSCRATCH  12'h140
`define CSR_ADDR_SEPC      12'h141
`define CSR_ADDR_SCAUSE    12'h142
`define CSR_ADDR_STVAL     12'h143

// -------------------------------------------------------------------------
// Machine trap setup and handling
`define CSR_ADDR_MSTATUS   12'h300
`define CSR_ADDR_MISA      12'h301
`define CSR_ADDR_MEDELEG   12'h302
`define CSR_ADDR_MTVEC     12'h305
`define CSR_ADDR_MSCRATCH  12'h340
`define CSR_ADDR_MEPC      12'h341
`define CSR_ADDR_MCAUSE    12'h342
`define CSR_ADDR_MTVAL     12'h343

// Counters and machine information, all in the read-only region
`define CSR_ADDR_CYCLE     12'hc00
`define CSR_ADDR_CYCLEH    12'hc80
`define CSR_ADDR_MVENDORID 12'hf11
`define CSR_ADDR_MARCHID   12'hf12
`define CSR_ADDR_MIMPID    12'hf13
`define CSR_ADDR_MHARTID   12'hf14

// MXL=1 (32 bit), extension I only
`define CSR_MISA_VALUE     32'h4000_0100
`define CSR_VENDOR_ID      32'h0000_0000
`define CSR_ARCH_ID        32'h0000_0000
`define CSR_IMPL_ID        32'h0000_0000
`define CSR_HART_ID        32'h0000_0000

`endif
